//--- source/uartPkg.sv
/*
 * UART shared definitions
 * Register addresses, widths and the structs passed between the stages
 */
package uartPkg;

	localparam int REG_WIDTH = 8;
	localparam int ADDR_WIDTH = 3;
	localparam int APB_DATA_WIDTH = 32;
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_COUNT_WIDTH = 5;
	localparam int OVERSAMPLE = 16;

	// Register map, DLAB selects the aliases at 0 and 1
	localparam logic [ADDR_WIDTH-1:0] ADDR_RBR_THR = 3'd0;
	localparam logic [ADDR_WIDTH-1:0] ADDR_DLM_IER = 3'd1;
	localparam logic [ADDR_WIDTH-1:0] ADDR_FCR = 3'd2;
	localparam logic [ADDR_WIDTH-1:0] ADDR_LCR = 3'd3;
	localparam logic [ADDR_WIDTH-1:0] ADDR_MCR = 3'd4;
	localparam logic [ADDR_WIDTH-1:0] ADDR_LSR = 3'd5;
	localparam logic [ADDR_WIDTH-1:0] ADDR_MSR = 3'd6;
	localparam logic [ADDR_WIDTH-1:0] ADDR_SCR = 3'd7;

	// Same bit order as the LCR, dlab on bit 7
	typedef struct packed {
		logic dlab;
		logic bc;
		logic sp;
		logic eps;
		logic pen;
		logic stb;
		logic [1:0] wls;
	} lineCtrl_t;

	typedef struct packed {
		logic sel;
		logic enable;
		logic write;
		logic [ADDR_WIDTH-1:0] addr;
		logic [APB_DATA_WIDTH-1:0] wdata;
	} apbReq_t;

	typedef struct packed {
		logic bi;
		logic fe;
		logic pe;
		logic [REG_WIDTH-1:0] data;
	} rxEntry_t;

	typedef struct packed {
		lineCtrl_t line;
		logic loop;
		logic txClear;
		logic rxClear;
	} uartCtrl_t;

	typedef struct packed {
		logic empty;
		logic full;
		logic running;
	} txStatus_t;

	typedef struct packed {
		rxEntry_t head;
		logic empty;
		logic full;
		logic overrun;
	} rxStatus_t;

endpackage

//--- source/uartFifo.sv
/*
 * UART FIFO
 * Synchronous FIFO with clear, usage count and flags, head shown combinationally
 */
`timescale 1ns/1ns

module uartFifo #(
	parameter int WIDTH = 8
) (
	input  logic CLK,
	input  logic iRST,
	input  logic clear,
	input  logic write,
	input  logic read,
	input  logic [WIDTH-1:0] wdata,
	output logic [WIDTH-1:0] rdata,
	output logic empty,
	output logic full,
	output logic [uartPkg::FIFO_COUNT_WIDTH-1:0] usage
);

	logic [WIDTH-1:0] mem [uartPkg::FIFO_DEPTH];
	logic [$clog2(uartPkg::FIFO_DEPTH)-1:0] wrPtr;
	logic [$clog2(uartPkg::FIFO_DEPTH)-1:0] rdPtr;
	logic doWrite;
	logic doRead;

	assign doWrite = write && !full;
	assign doRead = read && !empty;
	assign empty = usage == '0;
	assign full = usage == uartPkg::FIFO_COUNT_WIDTH'(uartPkg::FIFO_DEPTH);
	assign rdata = mem[rdPtr];

	always_ff @(posedge CLK)
	begin
		if (doWrite)
			mem[wrPtr] <= wdata;
	end

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			usage <= '0;
		end
		else if (clear)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			usage <= '0;
		end
		else
		begin
			if (doWrite)
				wrPtr <= wrPtr + 1'b1;
			if (doRead)
				rdPtr <= rdPtr + 1'b1;
			// Simultaneous push and pop leaves the count alone
			case ({doWrite, doRead})
				2'b10: usage <= usage + 1'b1;
				2'b01: usage <= usage - 1'b1;
				default: usage <= usage;
			endcase
		end
	end

endmodule

//--- source/uartRegisterFile.sv
/*
 * UART register file
 * APB decode, configuration registers, sticky line status and read mux
 */
`timescale 1ns/1ns

module uartRegisterFile (
	input  logic CLK,
	input  logic iRST,
	input  uartPkg::apbReq_t apbReq,
	output logic [uartPkg::APB_DATA_WIDTH-1:0] readData,
	output uartPkg::uartCtrl_t ctrl,
	output logic [15:0] divisor,
	output logic thrWrite,
	output logic [uartPkg::REG_WIDTH-1:0] thrData,
	output logic rbrRead,
	input  uartPkg::txStatus_t txStatus,
	input  uartPkg::rxStatus_t rxStatus
);

	logic regWrite;
	logic regRead;
	logic lsrRead;
	logic [uartPkg::REG_WIDTH-1:0] dll;
	logic [uartPkg::REG_WIDTH-1:0] dlm;
	logic [uartPkg::REG_WIDTH-1:0] scr;
	uartPkg::lineCtrl_t lcr;
	logic loopMode;
	logic txClearQ;
	logic rxClearQ;
	logic lsrOe;
	logic lsrPe;
	logic lsrFe;
	logic lsrBi;
	logic rxEmptyQ;
	logic rbrReadQ;
	logic headFresh;
	logic [uartPkg::REG_WIDTH-1:0] lsr;
	logic [uartPkg::REG_WIDTH-1:0] readByte;

	assign regWrite = apbReq.sel && apbReq.enable && apbReq.write;
	assign regRead = apbReq.sel && apbReq.enable && !apbReq.write;
	assign thrWrite = regWrite && apbReq.addr == uartPkg::ADDR_RBR_THR && !lcr.dlab;
	assign thrData = apbReq.wdata[uartPkg::REG_WIDTH-1:0];
	assign rbrRead = regRead && apbReq.addr == uartPkg::ADDR_RBR_THR && !lcr.dlab;
	assign lsrRead = regRead && apbReq.addr == uartPkg::ADDR_LSR;

	assign divisor = {dlm, dll};
	assign ctrl = '{line: lcr, loop: loopMode, txClear: txClearQ, rxClear: rxClearQ};

	// A head is new after a push into an empty FIFO or after a pop
	assign headFresh = !rxStatus.empty && (rxEmptyQ || rbrReadQ);

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			dll <= '0;
			dlm <= '0;
			scr <= '0;
			lcr <= '0;
			loopMode <= 1'b0;
			txClearQ <= 1'b0;
			rxClearQ <= 1'b0;
		end
		else
		begin
			txClearQ <= 1'b0;
			rxClearQ <= 1'b0;
			if (regWrite)
			begin
				case (apbReq.addr)
					uartPkg::ADDR_RBR_THR: if (lcr.dlab) dll <= thrData;
					uartPkg::ADDR_DLM_IER: if (lcr.dlab) dlm <= thrData;
					uartPkg::ADDR_FCR:
					begin
						rxClearQ <= apbReq.wdata[1];
						txClearQ <= apbReq.wdata[2];
					end
					uartPkg::ADDR_LCR: lcr <= uartPkg::lineCtrl_t'(thrData);
					uartPkg::ADDR_MCR: loopMode <= apbReq.wdata[4];
					uartPkg::ADDR_SCR: scr <= thrData;
					default: ;
				endcase
			end
		end
	end

	// Sticky error bits, a new event wins over the clearing read
	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			lsrOe <= 1'b0;
			lsrPe <= 1'b0;
			lsrFe <= 1'b0;
			lsrBi <= 1'b0;
			rxEmptyQ <= 1'b1;
			rbrReadQ <= 1'b0;
		end
		else
		begin
			rxEmptyQ <= rxStatus.empty;
			rbrReadQ <= rbrRead;
			if (rxStatus.overrun)
				lsrOe <= 1'b1;
			else if (lsrRead)
				lsrOe <= 1'b0;
			if (headFresh && rxStatus.head.pe)
				lsrPe <= 1'b1;
			else if (lsrRead)
				lsrPe <= 1'b0;
			if (headFresh && rxStatus.head.fe)
				lsrFe <= 1'b1;
			else if (lsrRead)
				lsrFe <= 1'b0;
			if (headFresh && rxStatus.head.bi)
				lsrBi <= 1'b1;
			else if (lsrRead)
				lsrBi <= 1'b0;
		end
	end

	// Bit 7 is the FIFO error flag, not kept here
	assign lsr = {1'b0, txStatus.empty && !txStatus.running, txStatus.empty,
		lsrBi, lsrFe, lsrPe, lsrOe, !rxStatus.empty};

	always_comb
	begin
		case (apbReq.addr)
			uartPkg::ADDR_RBR_THR: readByte = lcr.dlab ? dll : rxStatus.head.data;
			uartPkg::ADDR_DLM_IER: readByte = lcr.dlab ? dlm : '0;
			uartPkg::ADDR_FCR: readByte = '0;
			uartPkg::ADDR_LCR: readByte = lcr;
			uartPkg::ADDR_MCR: readByte = {3'b000, loopMode, 4'b0000};
			uartPkg::ADDR_LSR: readByte = lsr;
			uartPkg::ADDR_MSR: readByte = '0;
			default: readByte = scr;
		endcase
	end

	assign readData = {{(uartPkg::APB_DATA_WIDTH - uartPkg::REG_WIDTH){1'b0}}, readByte};

endmodule

//--- source/uartBaudGenerator.sv
/*
 * UART baud generator
 * Divides the clock by the divisor latch into a 16x oversampling tick
 */
`timescale 1ns/1ns

module uartBaudGenerator (
	input  logic CLK,
	input  logic iRST,
	input  logic [15:0] divisor,
	output logic tick16
);

	logic [15:0] count;
	logic [15:0] lastDivisor;
	logic restart;

	// Any change of the divisor starts a fresh period
	assign restart = divisor != lastDivisor;

	// Divisor 0 loads 0 so count never reaches 1
	assign tick16 = !restart && count == 16'd1;

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			count <= '0;
			lastDivisor <= '0;
		end
		else
		begin
			lastDivisor <= divisor;
			if (restart || count <= 16'd1)
				count <= divisor;
			else
				count <= count - 1'b1;
		end
	end

endmodule

//--- source/uartTransmitPath.sv
/*
 * UART transmit path
 * TX FIFO and serializer for 5 to 8 data bits, parity, 1 to 2 stop bits and break
 */
`timescale 1ns/1ns

module uartTransmitPath (
	input  logic CLK,
	input  logic iRST,
	input  uartPkg::uartCtrl_t ctrl,
	input  logic tick16,
	input  logic thrWrite,
	input  logic [uartPkg::REG_WIDTH-1:0] thrData,
	output logic txLine,
	output uartPkg::txStatus_t status
);

	typedef enum logic [1:0] {stIdle, stLoad, stShift, stStop} txState_t;

	txState_t state;
	logic pop;
	logic fifoEmpty;
	logic fifoFull;
	logic [uartPkg::REG_WIDTH-1:0] fifoData;
	logic [uartPkg::REG_WIDTH-1:0] shiftReg;
	logic [3:0] tickCount;
	logic [3:0] bitsLeft;
	logic [2:0] stopHalves;
	logic parityAcc;
	logic parityBit;
	logic serialLine;
	logic running;

	uartFifo #(.WIDTH(uartPkg::REG_WIDTH)) txFifo_i (
		.CLK(CLK),
		.iRST(iRST),
		.clear(ctrl.txClear),
		.write(thrWrite),
		.read(pop),
		.wdata(thrData),
		.rdata(fifoData),
		.empty(fifoEmpty),
		.full(fifoFull),
		.usage()
	);

	assign pop = state == stIdle && !fifoEmpty;
	// Stick parity sends NOT eps, otherwise XOR of the data flipped for odd
	assign parityBit = (ctrl.line.sp ? 1'b0 : parityAcc) ^ !ctrl.line.eps;
	assign txLine = serialLine && !ctrl.line.bc;
	assign status = '{empty: fifoEmpty, full: fifoFull, running: running};

	always_ff @(posedge CLK)
	begin
		if (pop)
			shiftReg <= fifoData;
		else if (state == stShift && tick16 && tickCount == 4'(uartPkg::OVERSAMPLE - 1)
			&& !(ctrl.line.pen && bitsLeft == 4'd1))
			shiftReg <= shiftReg >> 1;
	end

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			state <= stIdle;
			serialLine <= 1'b1;
			running <= 1'b0;
			tickCount <= '0;
			bitsLeft <= '0;
			stopHalves <= '0;
			parityAcc <= 1'b0;
		end
		else
		begin
			case (state)
				stIdle:
				begin
					serialLine <= 1'b1;
					parityAcc <= 1'b0;
					if (pop)
					begin
						running <= 1'b1;
						state <= stLoad;
					end
				end
				stLoad:
				begin
					// Start bit, then data plus optional parity
					serialLine <= 1'b0;
					tickCount <= '0;
					bitsLeft <= 4'(ctrl.line.wls) + 4'd5 + 4'(ctrl.line.pen);
					state <= stShift;
				end
				stShift:
				begin
					if (tick16)
					begin
						if (tickCount == 4'(uartPkg::OVERSAMPLE - 1))
						begin
							tickCount <= '0;
							if (bitsLeft == '0)
							begin
								serialLine <= 1'b1;
								// Stop length counted in half bits
								stopHalves <= !ctrl.line.stb ? 3'd2 :
									(ctrl.line.wls == 2'd0 ? 3'd3 : 3'd4);
								state <= stStop;
							end
							else if (ctrl.line.pen && bitsLeft == 4'd1)
								serialLine <= parityBit;
							else
							begin
								serialLine <= shiftReg[0];
								parityAcc <= parityAcc ^ shiftReg[0];
							end
							if (bitsLeft != '0)
								bitsLeft <= bitsLeft - 1'b1;
						end
						else
							tickCount <= tickCount + 1'b1;
					end
				end
				default:
				begin
					if (tick16)
					begin
						if (tickCount == 4'(uartPkg::OVERSAMPLE / 2 - 1))
						begin
							tickCount <= '0;
							stopHalves <= stopHalves - 1'b1;
							if (stopHalves == 3'd1)
							begin
								running <= 1'b0;
								state <= stIdle;
							end
						end
						else
							tickCount <= tickCount + 1'b1;
					end
				end
			endcase
		end
	end

endmodule

//--- source/uartReceivePath.sv
/*
 * UART receive path
 * Input sync, loopback select, 16x oversampling deserializer and RX FIFO
 */
`timescale 1ns/1ns

module uartReceivePath (
	input  logic CLK,
	input  logic iRST,
	input  uartPkg::uartCtrl_t ctrl,
	input  logic tick16,
	input  logic sin,
	input  logic txLine,
	input  logic rbrRead,
	output uartPkg::rxStatus_t status
);

	typedef enum logic [1:0] {stIdle, stStart, stData, stStop} rxState_t;

	rxState_t state;
	logic [1:0] syncQ;
	logic line;
	logic lineQ;
	logic [3:0] tickCount;
	logic [3:0] bitsLeft;
	logic [uartPkg::REG_WIDTH-1:0] shiftReg;
	logic [uartPkg::REG_WIDTH-1:0] aligned;
	logic rxParity;
	logic parityError;
	logic pending;
	uartPkg::rxEntry_t entry;
	uartPkg::rxEntry_t head;
	logic fifoEmpty;
	logic fifoFull;

	uartFifo #(.WIDTH($bits(uartPkg::rxEntry_t))) rxFifo_i (
		.CLK(CLK),
		.iRST(iRST),
		.clear(ctrl.rxClear),
		.write(pending),
		.read(rbrRead),
		.wdata(entry),
		.rdata(head),
		.empty(fifoEmpty),
		.full(fifoFull),
		.usage()
	);

	assign line = ctrl.loop ? txLine : syncQ[1];

	// Bits arrive LSB first into the top, short words need moving down
	assign aligned = shiftReg >> (2'd3 - ctrl.line.wls);
	assign parityError = ctrl.line.pen &&
		(rxParity != ((ctrl.line.sp ? 1'b0 : ^aligned) ^ !ctrl.line.eps));

	assign status = '{head: head, empty: fifoEmpty, full: fifoFull,
		overrun: pending && fifoFull};

	always_ff @(posedge CLK)
	begin
		if (state == stData && tick16 && tickCount == 4'(uartPkg::OVERSAMPLE - 1))
		begin
			if (ctrl.line.pen && bitsLeft == 4'd1)
				rxParity <= line;
			else
				shiftReg <= {line, shiftReg[uartPkg::REG_WIDTH-1:1]};
		end
		if (state == stStop && tick16 && tickCount == 4'(uartPkg::OVERSAMPLE - 1))
		begin
			entry.data <= aligned;
			entry.pe <= parityError;
			entry.fe <= !line;
			entry.bi <= !line && aligned == '0 && !(ctrl.line.pen && rxParity);
		end
	end

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			syncQ <= 2'b11;
			lineQ <= 1'b1;
			state <= stIdle;
			tickCount <= '0;
			bitsLeft <= '0;
			pending <= 1'b0;
		end
		else
		begin
			syncQ <= {syncQ[0], sin};
			lineQ <= line;
			pending <= 1'b0;
			case (state)
				stIdle:
				begin
					tickCount <= '0;
					if (lineQ && !line)
						state <= stStart;
				end
				stStart:
				begin
					if (tick16)
					begin
						tickCount <= tickCount + 1'b1;
						// Middle of the start bit, reject glitches
						if (tickCount == 4'(uartPkg::OVERSAMPLE / 2 - 1))
						begin
							tickCount <= '0;
							bitsLeft <= 4'(ctrl.line.wls) + 4'd5 + 4'(ctrl.line.pen);
							state <= line ? stIdle : stData;
						end
					end
				end
				stData:
				begin
					if (tick16)
					begin
						tickCount <= tickCount + 1'b1;
						if (tickCount == 4'(uartPkg::OVERSAMPLE - 1))
						begin
							bitsLeft <= bitsLeft - 1'b1;
							if (bitsLeft == 4'd1)
								state <= stStop;
						end
					end
				end
				default:
				begin
					if (tick16)
					begin
						tickCount <= tickCount + 1'b1;
						if (tickCount == 4'(uartPkg::OVERSAMPLE - 1))
						begin
							pending <= 1'b1;
							state <= stIdle;
						end
					end
				end
			endcase
		end
	end

endmodule

//--- source/apbUart.sv
/*
 * APB UART top level
 * Register file, baud generator and both serial paths, with the registered SOUT
 */
`timescale 1ns/1ns

module apbUart (
	input  logic CLK,
	input  logic iRST,
	input  uartPkg::apbReq_t apbReq,
	output logic [uartPkg::APB_DATA_WIDTH-1:0] readData,
	input  logic sin,
	output logic sout
);

	uartPkg::uartCtrl_t ctrl;
	uartPkg::txStatus_t txStatus;
	uartPkg::rxStatus_t rxStatus;
	logic [15:0] divisor;
	logic thrWrite;
	logic [uartPkg::REG_WIDTH-1:0] thrData;
	logic rbrRead;
	logic tick16;
	logic txLine;

	uartRegisterFile registerFile_i (
		.CLK(CLK),
		.iRST(iRST),
		.apbReq(apbReq),
		.readData(readData),
		.ctrl(ctrl),
		.divisor(divisor),
		.thrWrite(thrWrite),
		.thrData(thrData),
		.rbrRead(rbrRead),
		.txStatus(txStatus),
		.rxStatus(rxStatus)
	);

	uartBaudGenerator baudGenerator_i (
		.CLK(CLK),
		.iRST(iRST),
		.divisor(divisor),
		.tick16(tick16)
	);

	uartTransmitPath transmitPath_i (
		.CLK(CLK),
		.iRST(iRST),
		.ctrl(ctrl),
		.tick16(tick16),
		.thrWrite(thrWrite),
		.thrData(thrData),
		.txLine(txLine),
		.status(txStatus)
	);

	uartReceivePath receivePath_i (
		.CLK(CLK),
		.iRST(iRST),
		.ctrl(ctrl),
		.tick16(tick16),
		.sin(sin),
		.txLine(txLine),
		.rbrRead(rbrRead),
		.status(rxStatus)
	);

	// Line idles high, and stays high while the serializer is looped back
	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
			sout <= 1'b1;
		else
			sout <= ctrl.loop || txLine;
	end

endmodule

//--- verification/apbUart_sva.sv
/*
 * APB UART assertions
 * Loopback line level, strobes under reset and the silent baud tick
 */
`timescale 1ns/1ns

module apbUartSva (
	input logic CLK,
	input logic iRST,
	input logic loop,
	input logic sout,
	input logic thrWrite,
	input logic rbrRead,
	input logic tick16,
	input logic [15:0] divisor
);

	// sout is registered, so it follows loop one cycle later
	soutHighInLoop: assert property (@(posedge CLK) disable iff (iRST) loop |=> sout)
		else $error("sout left 1 while loop mode was set");

	strobesQuietInReset: assert property (@(posedge CLK) iRST |-> !(thrWrite || rbrRead))
		else $error("thrWrite or rbrRead high during reset");

	noTickAtZeroDivisor: assert property (@(posedge CLK) disable iff (iRST)
		divisor == 16'd0 |-> !tick16)
		else $error("tick16 pulsed with a zero divisor");

endmodule

bind apbUart apbUartSva sva_i (
	.CLK(CLK),
	.iRST(iRST),
	.loop(ctrl.loop),
	.sout(sout),
	.thrWrite(thrWrite),
	.rbrRead(rbrRead),
	.tick16(tick16),
	.divisor(divisor)
);

//--- verification/apbUartTb.sv
/*
 * APB UART testbench
 * Register access, TX frame checks against a reference, loopback and RX errors
 */
`timescale 1ns/1ns

module apbUartTb;

	localparam int DIVISOR = 2;
	localparam int BIT_CLOCKS = uartPkg::OVERSAMPLE * DIVISOR;
	localparam int BIT_NS = BIT_CLOCKS * 4;
	localparam int TOTAL_FRAMES = 64 + 16 + 3 + 17 + 6;
	localparam int TIMEOUT_NS = TOTAL_FRAMES * 12 * BIT_NS * 2 + 50000;

	logic CLK;
	logic iRST;
	uartPkg::apbReq_t apbReq;
	logic [uartPkg::APB_DATA_WIDTH-1:0] readData;
	logic sin;
	logic sout;

	logic [31:0] lfsrState;
	int errorCount;
	int checkCount;
	int framesSeen;
	bit checkFrames;
	logic [15:0] expFrame;
	int expLen;

	apbUart dut_i (
		.CLK(CLK),
		.iRST(iRST),
		.apbReq(apbReq),
		.readData(readData),
		.sin(sin),
		.sout(sout)
	);

	initial
	begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("Watchdog expired before the tests completed");
		$display("Some tests failed");
		$finish;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [7:0] randomByte();
		logic [7:0] b;
		for (int i = 0; i < 8; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			b[i] = lfsrState[0];
		end
		return b;
	endfunction

	// Even parity when eps set, odd otherwise, stick sends NOT eps
	function automatic logic refParity(input logic [7:0] data, input logic [7:0] lcr);
		logic [7:0] mask;
		mask = 8'hff >> (3 - lcr[1:0]);
		if (lcr[5])
			return !lcr[4];
		return ^(data & mask) ^ !lcr[4];
	endfunction

	// Bit 0 is the start bit, 1.5 stop bits are checked as one
	function automatic logic [15:0] refFrame(input logic [7:0] data, input logic [7:0] lcr,
		output int len);
		logic [15:0] bits;
		int nbits;
		int pos;
		bits = '1;
		nbits = lcr[1:0] + 5;
		bits[0] = 1'b0;
		for (int i = 0; i < nbits; i++)
			bits[1 + i] = data[i];
		pos = nbits + 1;
		if (lcr[3])
		begin
			bits[pos] = refParity(data, lcr);
			pos++;
		end
		len = pos + ((lcr[2] && lcr[1:0] != 2'd0) ? 2 : 1);
		return bits;
	endfunction

	task automatic checkValue(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("FAIL %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic writeReg(input logic [2:0] addr, input logic [7:0] data);
		@(posedge CLK);
		apbReq <= '{sel: 1'b1, enable: 1'b0, write: 1'b1, addr: addr, wdata: 32'(data)};
		@(posedge CLK);
		apbReq.enable <= 1'b1;
		@(posedge CLK);
		apbReq <= '0;
	endtask

	task automatic readReg(input logic [2:0] addr, output logic [7:0] data);
		@(posedge CLK);
		apbReq <= '{sel: 1'b1, enable: 1'b0, write: 1'b0, addr: addr, wdata: '0};
		@(posedge CLK);
		apbReq.enable <= 1'b1;
		@(negedge CLK);
		checkValue("upper read bits", readData[31:8], 32'h0);
		data = readData[7:0];
		@(posedge CLK);
		apbReq <= '0;
	endtask

	task automatic expectReg(input string what, input logic [2:0] addr,
		input logic [7:0] mask, input logic [7:0] exp);
		logic [7:0] data;
		readReg(addr, data);
		checkValue(what, data & mask, exp);
	endtask

	task automatic waitTxDone();
		logic [7:0] lsr;
		int polls;
		polls = 0;
		lsr = '0;
		while (!lsr[6] && polls < 4000)
		begin
			readReg(uartPkg::ADDR_LSR, lsr);
			polls++;
		end
		if (!lsr[6])
		begin
			errorCount++;
			$display("TEMT did not set within the polling limit at %0t", $time);
		end
	endtask

	task automatic holdBit(input logic b);
		@(posedge CLK);
		sin <= b;
		repeat (BIT_CLOCKS - 1) @(posedge CLK);
	endtask

	task automatic sendSerial(input logic [7:0] data, input int nbits, input logic usePar,
		input logic parBit, input logic stopBit);
		holdBit(1'b0);
		for (int i = 0; i < nbits; i++)
			holdBit(data[i]);
		if (usePar)
			holdBit(parBit);
		holdBit(stopBit);
		holdBit(1'b1);
	endtask

	// Samples sout at mid-bit after each start edge
	initial
	begin
		framesSeen = 0;
		forever
		begin
			@(negedge sout);
			if (checkFrames)
			begin
				#(BIT_NS / 2);
				for (int i = 0; i < expLen; i++)
				begin
					checkCount++;
					if (sout !== expFrame[i])
					begin
						errorCount++;
						$display("FAIL %0t: frame bit %0d is %b, expected %b",
							$time, i, sout, expFrame[i]);
					end
					if (i < expLen - 1)
						#(BIT_NS);
				end
				framesSeen++;
			end
		end
	end

	// Flags sout leaving 1 during the loopback test
	bit loopWatch;
	always @(posedge CLK)
	begin
		if (loopWatch && sout !== 1'b1)
		begin
			errorCount++;
			$display("FAIL %0t: sout went low in loop mode", $time);
		end
	end

	initial
	begin
		logic [7:0] lcr;
		logic [7:0] b;
		logic [7:0] sent [17];
		iRST = 1'b1;
		apbReq = '0;
		sin = 1'b1;
		lfsrState = 32'hf644379c;
		errorCount = 0;
		checkCount = 0;
		checkFrames = 1'b0;
		loopWatch = 1'b0;
		expFrame = '1;
		expLen = 0;
		repeat (5) @(posedge CLK);
		iRST <= 1'b0;

		// Reset values
		checkValue("sout after reset", sout, 1'b1);
		expectReg("LCR", uartPkg::ADDR_LCR, 8'hff, 8'h00);
		expectReg("MCR", uartPkg::ADDR_MCR, 8'hff, 8'h00);
		expectReg("SCR", uartPkg::ADDR_SCR, 8'hff, 8'h00);
		expectReg("LSR", uartPkg::ADDR_LSR, 8'hff, 8'h60);
		writeReg(uartPkg::ADDR_LCR, 8'h80);
		expectReg("DLL", uartPkg::ADDR_RBR_THR, 8'hff, 8'h00);
		expectReg("DLM", uartPkg::ADDR_DLM_IER, 8'hff, 8'h00);

		// Read back
		writeReg(uartPkg::ADDR_SCR, 8'ha5);
		expectReg("SCR", uartPkg::ADDR_SCR, 8'hff, 8'ha5);
		writeReg(uartPkg::ADDR_RBR_THR, 8'h34);
		writeReg(uartPkg::ADDR_DLM_IER, 8'h12);
		expectReg("DLL", uartPkg::ADDR_RBR_THR, 8'hff, 8'h34);
		expectReg("DLM", uartPkg::ADDR_DLM_IER, 8'hff, 8'h12);
		expectReg("LCR", uartPkg::ADDR_LCR, 8'hff, 8'h80);
		expectReg("FCR/IIR", uartPkg::ADDR_FCR, 8'hff, 8'h00);
		expectReg("MSR", uartPkg::ADDR_MSR, 8'hff, 8'h00);
		writeReg(uartPkg::ADDR_RBR_THR, 8'(DIVISOR));
		writeReg(uartPkg::ADDR_DLM_IER, 8'h00);
		writeReg(uartPkg::ADDR_LCR, 8'h1b);
		expectReg("LCR", uartPkg::ADDR_LCR, 8'hff, 8'h1b);

		// Every frame format on sout
		for (int idx = 0; idx < 64; idx++)
		begin
			lcr = 8'(idx);
			writeReg(uartPkg::ADDR_LCR, lcr);
			b = randomByte();
			expFrame = refFrame(b, lcr, expLen);
			checkFrames = 1'b1;
			writeReg(uartPkg::ADDR_RBR_THR, b);
			waitTxDone();
		end
		checkFrames = 1'b0;
		checkValue("frames seen", framesSeen, 64);

		// Loopback
		writeReg(uartPkg::ADDR_LCR, 8'h02);
		writeReg(uartPkg::ADDR_MCR, 8'h10);
		loopWatch = 1'b1;
		for (int i = 0; i < 16; i++)
		begin
			sent[i] = randomByte();
			writeReg(uartPkg::ADDR_RBR_THR, sent[i]);
		end
		waitTxDone();
		expectReg("LSR DR", uartPkg::ADDR_LSR, 8'h01, 8'h01);
		for (int i = 0; i < 16; i++)
			expectReg("loop RBR", uartPkg::ADDR_RBR_THR, 8'hff, sent[i] & 8'h7f);
		expectReg("LSR DR", uartPkg::ADDR_LSR, 8'h01, 8'h00);
		loopWatch = 1'b0;
		writeReg(uartPkg::ADDR_MCR, 8'h00);

		// Receive errors, odd parity first
		writeReg(uartPkg::ADDR_LCR, 8'h0b);
		sendSerial(8'h5a, 8, 1'b1, !refParity(8'h5a, 8'h0b), 1'b1);
		expectReg("LSR PE", uartPkg::ADDR_LSR, 8'h1f, 8'h05);
		expectReg("LSR PE cleared", uartPkg::ADDR_LSR, 8'h1f, 8'h01);
		expectReg("RBR", uartPkg::ADDR_RBR_THR, 8'hff, 8'h5a);
		writeReg(uartPkg::ADDR_LCR, 8'h03);
		sendSerial(8'hc3, 8, 1'b0, 1'b0, 1'b0);
		expectReg("LSR FE", uartPkg::ADDR_LSR, 8'h1f, 8'h09);
		expectReg("LSR FE cleared", uartPkg::ADDR_LSR, 8'h1f, 8'h01);
		expectReg("RBR", uartPkg::ADDR_RBR_THR, 8'hff, 8'hc3);
		sendSerial(8'h00, 8, 1'b0, 1'b0, 1'b0);
		expectReg("LSR BI", uartPkg::ADDR_LSR, 8'h1f, 8'h19);
		expectReg("LSR BI cleared", uartPkg::ADDR_LSR, 8'h1f, 8'h01);
		expectReg("RBR", uartPkg::ADDR_RBR_THR, 8'hff, 8'h00);
		for (int i = 0; i < 17; i++)
		begin
			sent[i] = randomByte();
			sendSerial(sent[i], 8, 1'b0, 1'b0, 1'b1);
		end
		expectReg("LSR OE", uartPkg::ADDR_LSR, 8'h03, 8'h03);
		expectReg("LSR OE cleared", uartPkg::ADDR_LSR, 8'h02, 8'h00);
		for (int i = 0; i < 16; i++)
			expectReg("RBR after overrun", uartPkg::ADDR_RBR_THR, 8'hff, sent[i]);
		expectReg("LSR DR", uartPkg::ADDR_LSR, 8'h01, 8'h00);

		// FIFO clear
		sendSerial(8'h11, 8, 1'b0, 1'b0, 1'b1);
		sendSerial(8'h22, 8, 1'b0, 1'b0, 1'b1);
		for (int i = 0; i < 4; i++)
			writeReg(uartPkg::ADDR_RBR_THR, randomByte());
		writeReg(uartPkg::ADDR_FCR, 8'h06);
		expectReg("LSR after clear", uartPkg::ADDR_LSR, 8'h21, 8'h20);
		waitTxDone();

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- apbUart.f
source/uartPkg.sv
source/uartFifo.sv
source/uartRegisterFile.sv
source/uartBaudGenerator.sv
source/uartTransmitPath.sv
source/uartReceivePath.sv
source/apbUart.sv
verification/apbUart_sva.sv
verification/apbUartTb.sv

//--- Bender.yml
package:
  name: apbUart

sources:
  - source/uartPkg.sv
  - source/uartFifo.sv
  - source/uartRegisterFile.sv
  - source/uartBaudGenerator.sv
  - source/uartTransmitPath.sv
  - source/uartReceivePath.sv
  - source/apbUart.sv
  - target: test
    files:
      - verification/apbUart_sva.sv
      - verification/apbUartTb.sv
